//--- src/merge_pkg.sv
package merge_pkg;

   // ==============================
   // Sizing
   // ==============================

   localparam int KEY_W      = 32;
   localparam int TUPLE_N    = 16;  // Keys per tuple
   localparam int FIFO_DEPTH = 16;  // Power of two
   localparam int OUT_SLACK  = 3;   // Two network stages plus flush register

   // ==============================
   // Types
   // ==============================

   // Key 0 is the smallest
   typedef logic [TUPLE_N-1:0][KEY_W-1:0] tuple_t;

   // Network working vector, picked tuple low, reversed held tuple high
   typedef logic [2*TUPLE_N-1:0][KEY_W-1:0] wide_t;

   // Travels with the vector through both stages
   typedef struct packed {
      logic valid;  // Merge in this stage
      logic emit;   // Lower half goes out
      logic term;   // End of streams, flush then terminator
   } stage_ctl_t;

endpackage

//--- src/tuple_fifo.sv
`timescale 1ns/1ps

module tuple_fifo (
   input  logic                i_clk,
   input  logic                i_arst_n,
   input  merge_pkg::tuple_t   i_data,
   input  logic                i_enq,
   input  logic                i_deq,
   output merge_pkg::tuple_t   o_data,
   output logic                o_empty,
   output logic                o_full,
   output logic                o_almost_full
);

   localparam int AW = $clog2(merge_pkg::FIFO_DEPTH);
   localparam int CW = $clog2(merge_pkg::FIFO_DEPTH + 1);

   merge_pkg::tuple_t mem [merge_pkg::FIFO_DEPTH];

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (i_enq) wr_ptr <= wr_ptr + 1'b1;  // Wraps, depth is 2**AW
         if (i_deq) rd_ptr <= rd_ptr + 1'b1;
         case ({i_enq, i_deq})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_enq) begin
         mem[wr_ptr] <= i_data;
      end
   end

   assign o_data  = mem[rd_ptr];  // Head falls through
   assign o_empty = (count == '0);
   assign o_full  = (count == CW'(merge_pkg::FIFO_DEPTH));

   // Fewer free entries than one issue may still produce
   assign o_almost_full = (CW'(merge_pkg::FIFO_DEPTH) - count) < CW'(merge_pkg::OUT_SLACK);

   // ==============================
   // Checks
   // ==============================

   a_no_overrun : assert property (
      @(posedge i_clk) disable iff (!i_arst_n) i_enq |-> (!o_full || i_deq)
   ) else $error("tuple_fifo: enqueue while full");

   a_no_underrun : assert property (
      @(posedge i_clk) disable iff (!i_arst_n) i_deq |-> !o_empty
   ) else $error("tuple_fifo: dequeue while empty");

endmodule

//--- src/merge_control.sv
`timescale 1ns/1ps

module merge_control (
   input  logic                   i_clk,
   input  logic                   i_arst_n,
   input  merge_pkg::tuple_t      i_a_head,
   input  logic                   i_a_empty,
   input  merge_pkg::tuple_t      i_b_head,
   input  logic                   i_b_empty,
   input  logic                   i_out_almost_full,
   output logic                   o_pop_a,
   output logic                   o_pop_b,
   output logic                   o_sel_a,
   output merge_pkg::stage_ctl_t  o_ctl
);

   typedef enum logic [1:0] {
      ST_PRIME,  // Nothing held yet
      ST_MERGE,
      ST_WAIT,   // Result still in the network
      ST_FLUSH   // Held tuple and terminator going out
   } state_t;

   state_t     state;
   state_t     state_nxt;
   logic [1:0] flush_cnt;
   logic       a_term;
   logic       b_term;
   logic       both_term;
   logic       a_first;
   logic       heads_ok;

   // ==============================
   // Head compare
   // ==============================

   assign a_term    = (i_a_head[0] == '0);
   assign b_term    = (i_b_head[0] == '0);
   assign both_term = a_term & b_term;

   // A terminator ranks above every real key
   assign a_first = b_term | (!a_term & (i_a_head[0] <= i_b_head[0]));

   // Both heads must be visible to know which is smaller
   assign heads_ok = !i_a_empty & !i_b_empty & !i_out_almost_full;

   // ==============================
   // FSM
   // ==============================

   always_comb begin
      state_nxt = state;
      o_ctl     = '0;
      case (state)
         ST_PRIME, ST_MERGE: begin
            if (heads_ok) begin
               o_ctl.valid = 1'b1;
               o_ctl.emit  = (state == ST_MERGE);  // Prime result is only held
               o_ctl.term  = both_term;
               state_nxt   = both_term ? ST_FLUSH : ST_WAIT;
            end
         end
         ST_WAIT: state_nxt = ST_MERGE;
         ST_FLUSH: begin
            if (flush_cnt == 2'd0) state_nxt = ST_PRIME;
         end
         default: state_nxt = ST_PRIME;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state     <= ST_PRIME;
         flush_cnt <= 2'd0;
      end else begin
         state <= state_nxt;
         if (o_ctl.valid && o_ctl.term) begin
            flush_cnt <= 2'd2;  // Covers network and the two output writes
         end else if (state == ST_FLUSH && flush_cnt != 2'd0) begin
            flush_cnt <= flush_cnt - 2'd1;
         end
      end
   end

   // Both terminators leave together
   assign o_pop_a = o_ctl.valid & (a_first | both_term);
   assign o_pop_b = o_ctl.valid & (!a_first | both_term);
   assign o_sel_a = a_first;

   // A head that is not popped stays in place
   a_head_hold_a : assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
         (!i_a_empty && !o_pop_a) |=> (!i_a_empty && $stable(i_a_head))
   ) else $error("merge_control: head A changed without a pop");

   a_head_hold_b : assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
         (!i_b_empty && !o_pop_b) |=> (!i_b_empty && $stable(i_b_head))
   ) else $error("merge_control: head B changed without a pop");

endmodule

//--- src/bitonic_merge_stage.sv
`timescale 1ns/1ps

module bitonic_merge_stage #(
   parameter int FIRST_LEVEL = 0,  // Level 0 compares across distance TUPLE_N
   parameter int NUM_LEVELS  = 3
) (
   input  logic                   i_clk,
   input  logic                   i_arst_n,
   input  merge_pkg::wide_t       i_vec,
   input  merge_pkg::stage_ctl_t  i_ctl,
   output merge_pkg::wide_t       o_vec,
   output merge_pkg::stage_ctl_t  o_ctl
);

   localparam int WIDE_N = 2 * merge_pkg::TUPLE_N;

   merge_pkg::wide_t lvl [NUM_LEVELS+1];

   assign lvl[0] = i_vec;

   // ==============================
   // Half-cleaner levels
   // ==============================

   for (genvar l = 0; l < NUM_LEVELS; l++) begin : g_level
      localparam int DIST = merge_pkg::TUPLE_N >> (FIRST_LEVEL + l);

      for (genvar i = 0; i < WIDE_N; i++) begin : g_key
         // Lower key of each pair owns the compare-exchange
         if ((i & DIST) == 0) begin : g_cmp
            logic swap;

            assign swap = lvl[l][i] > lvl[l][i+DIST];
            assign lvl[l+1][i]      = swap ? lvl[l][i+DIST] : lvl[l][i];
            assign lvl[l+1][i+DIST] = swap ? lvl[l][i]      : lvl[l][i+DIST];
         end
      end
   end

   // ==============================
   // Stage register
   // ==============================

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_ctl <= '0;
      end else begin
         o_ctl <= i_ctl;  // Valid lasts one cycle per issue
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_ctl.valid) begin
         o_vec <= lvl[NUM_LEVELS];
      end
   end

endmodule

//--- src/tuple_merger.sv
`timescale 1ns/1ps

module tuple_merger (
   input  logic               i_clk,
   input  logic               i_arst_n,
   input  merge_pkg::tuple_t  i_in_a_data,
   input  logic               i_in_a_empty,
   output logic               o_in_a_read,
   input  merge_pkg::tuple_t  i_in_b_data,
   input  logic               i_in_b_empty,
   output logic               o_in_b_read,
   input  logic               i_out_ready,
   output logic               o_out_write,
   output merge_pkg::tuple_t  o_out_data
);

   localparam int TN = merge_pkg::TUPLE_N;

   logic                   ready_q;
   logic                   a_empty;
   logic                   a_full;
   logic                   b_empty;
   logic                   b_full;
   logic                   out_empty;
   logic                   out_full;
   logic                   out_almost_full;
   logic                   out_enq;
   logic                   out_deq;
   logic                   pop_a;
   logic                   pop_b;
   logic                   sel_a;
   logic                   flush_q;
   merge_pkg::tuple_t      a_head;
   merge_pkg::tuple_t      b_head;
   merge_pkg::tuple_t      picked;
   merge_pkg::tuple_t      held_q;
   merge_pkg::tuple_t      held_src;
   merge_pkg::tuple_t      held_rev;
   merge_pkg::tuple_t      out_din;
   merge_pkg::wide_t       net_in;
   merge_pkg::wide_t       vec_1;
   merge_pkg::wide_t       vec_2;
   merge_pkg::stage_ctl_t  ctl_0;
   merge_pkg::stage_ctl_t  ctl_1;
   merge_pkg::stage_ctl_t  ctl_2;

   // ==============================
   // Input side
   // ==============================

   assign o_in_a_read = !i_in_a_empty & !a_full;
   assign o_in_b_read = !i_in_b_empty & !b_full;

   tuple_fifo u_fifo_a (
      .i_clk         (i_clk),
      .i_arst_n      (i_arst_n),
      .i_data        (i_in_a_data),
      .i_enq         (o_in_a_read),
      .i_deq         (pop_a),
      .o_data        (a_head),
      .o_empty       (a_empty),
      .o_full        (a_full),
      .o_almost_full ()
   );

   tuple_fifo u_fifo_b (
      .i_clk         (i_clk),
      .i_arst_n      (i_arst_n),
      .i_data        (i_in_b_data),
      .i_enq         (o_in_b_read),
      .i_deq         (pop_b),
      .o_data        (b_head),
      .o_empty       (b_empty),
      .o_full        (b_full),
      .o_almost_full ()
   );

   merge_control u_ctrl (
      .i_clk             (i_clk),
      .i_arst_n          (i_arst_n),
      .i_a_head          (a_head),
      .i_a_empty         (a_empty),
      .i_b_head          (b_head),
      .i_b_empty         (b_empty),
      .i_out_almost_full (out_almost_full),
      .o_pop_a           (pop_a),
      .o_pop_b           (pop_b),
      .o_sel_a           (sel_a),
      .o_ctl             (ctl_0)
   );

   // ==============================
   // Network
   // ==============================

   assign picked = sel_a ? a_head : b_head;

   // Stage 2 result lands in held_q at this edge, so bypass it
   assign held_src = ctl_2.valid ? vec_2[2*TN-1:TN] : held_q;

   always_comb begin
      for (int k = 0; k < TN; k++) begin
         held_rev[TN-1-k] = ctl_0.emit ? held_src[k] : '0;  // Zeros while priming
      end
   end

   assign net_in = {held_rev, picked};  // Ascending then descending

   bitonic_merge_stage #(.FIRST_LEVEL(0), .NUM_LEVELS(3)) u_stage_1 (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_vec    (net_in),
      .i_ctl    (ctl_0),
      .o_vec    (vec_1),
      .o_ctl    (ctl_1)
   );

   bitonic_merge_stage #(.FIRST_LEVEL(3), .NUM_LEVELS(2)) u_stage_2 (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_vec    (vec_1),
      .i_ctl    (ctl_1),
      .o_vec    (vec_2),
      .o_ctl    (ctl_2)
   );

   always_ff @(posedge i_clk) begin
      if (ctl_2.valid) begin
         held_q <= vec_2[2*TN-1:TN];  // Sixteen largest so far
      end
   end

   // ==============================
   // Output side
   // ==============================

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         ready_q <= 1'b0;
         flush_q <= 1'b0;
      end else begin
         ready_q <= i_out_ready;
         flush_q <= ctl_2.valid & ctl_2.term & ctl_2.emit;  // Terminator next cycle
      end
   end

   // A term slot merges zeros with the held tuple, so the upper half is the flush
   assign out_enq = (ctl_2.valid & (ctl_2.emit | ctl_2.term)) | flush_q;
   assign out_din = flush_q                   ? '0 :
                    (ctl_2.term & ctl_2.emit) ? vec_2[2*TN-1:TN] :
                                                vec_2[TN-1:0];

   assign out_deq     = ready_q & !out_empty;
   assign o_out_write = out_deq;

   tuple_fifo u_fifo_out (
      .i_clk         (i_clk),
      .i_arst_n      (i_arst_n),
      .i_data        (out_din),
      .i_enq         (out_enq),
      .i_deq         (out_deq),
      .o_data        (o_out_data),
      .o_empty       (out_empty),
      .o_full        (out_full),
      .o_almost_full (out_almost_full)
   );

   // Issue slack must cover everything still in flight
   a_out_no_overflow : assert property (
      @(posedge i_clk) disable iff (!i_arst_n) out_enq |-> !out_full
   ) else $error("tuple_merger: output FIFO written while full");

endmodule

//--- tb/tb_tuple_merger_data.svh
`ifndef TB_TUPLE_MERGER_DATA_SVH
`define TB_TUPLE_MERGER_DATA_SVH

// Key patterns
localparam int PAT_RANDOM     = 0;
localparam int PAT_INTERLEAVE = 1;
localparam int PAT_A_BELOW    = 2;  // Every A key below every B key
localparam int PAT_EQUAL      = 3;

typedef struct packed {
   int len_a;      // Tuples before the terminator
   int len_b;
   int pattern;
   int ready_pct;  // Downstream ready duty in percent
   int stall_len;  // Ready forced low from STALL_START on
} case_t;

localparam int NUM_CASES   = 12;
localparam int STALL_START = 10;

localparam case_t CASES [NUM_CASES] = '{
   // len_a len_b pattern ready stall
   '{3, 3, PAT_RANDOM,     100,   0},
   '{6, 4, PAT_RANDOM,      60,   0},
   '{0, 5, PAT_RANDOM,     100,   0},
   '{4, 0, PAT_INTERLEAVE,  80,   0},
   '{5, 5, PAT_INTERLEAVE, 100,   0},
   '{4, 4, PAT_A_BELOW,    100,   0},
   '{3, 6, PAT_A_BELOW,     50,   0},
   '{4, 4, PAT_EQUAL,      100,   0},
   '{6, 6, PAT_EQUAL,       70,   0},
   '{6, 6, PAT_RANDOM,     100, 120},
   '{0, 0, PAT_RANDOM,     100,   0},
   '{2, 5, PAT_RANDOM,      40,  80}
};

`endif

//--- tb/tb_tuple_merger.sv
`timescale 1ns/1ps

module tb_tuple_merger;

   localparam int          CLK_PERIOD   = 8;
   localparam int          RESET_CYCLES = 8;
   localparam int          IDLE_CYCLES  = 20;  // Quiet time after each terminator
   localparam int unsigned SEED         = 32'h9b2f9158;
   localparam int          TN           = merge_pkg::TUPLE_N;

   `include "tb_tuple_merger_data.svh"

   localparam int TIMEOUT_NS = (NUM_CASES * 400 + RESET_CYCLES) * CLK_PERIOD;

   logic              i_clk;
   logic              i_arst_n;
   merge_pkg::tuple_t i_in_a_data;
   logic              i_in_a_empty;
   logic              o_in_a_read;
   merge_pkg::tuple_t i_in_b_data;
   logic              i_in_b_empty;
   logic              o_in_b_read;
   logic              i_out_ready;
   logic              o_out_write;
   merge_pkg::tuple_t o_out_data;

   merge_pkg::tuple_t q_a [$];    // Upstream A, head shown to the DUT
   merge_pkg::tuple_t q_b [$];
   merge_pkg::tuple_t exp_q [$];  // Expected output tuples
   logic              ready_prev;
   int                errors = 0;
   int                checks = 0;

   tuple_merger u_dut (
      .i_clk        (i_clk),
      .i_arst_n     (i_arst_n),
      .i_in_a_data  (i_in_a_data),
      .i_in_a_empty (i_in_a_empty),
      .o_in_a_read  (o_in_a_read),
      .i_in_b_data  (i_in_b_data),
      .i_in_b_empty (i_in_b_empty),
      .o_in_b_read  (o_in_b_read),
      .i_out_ready  (i_out_ready),
      .o_out_write  (o_out_write),
      .o_out_data   (o_out_data)
   );

   initial begin
      i_clk = 1'b0;
      forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
   end

   // ==============================
   // Helpers
   // ==============================

   task automatic check_value(input string name, input logic [511:0] exp_val,
                              input logic [511:0] act_val);
      checks++;
      if (act_val !== exp_val) begin
         errors++;
         $display("error at %0t: %s expected %0h, got %0h", $time, name, exp_val, act_val);
      end
   endtask

   task automatic print_summary();
      $display("checks: %0d, errors: %0d", checks, errors);
   endtask

   function automatic int unsigned next_key(int pattern, int unsigned is_b, int i,
                                            int unsigned base, int unsigned prev);
      case (pattern)
         PAT_RANDOM:     return prev + ($urandom % 600);
         PAT_INTERLEAVE: return base + 2 * i + is_b;
         PAT_A_BELOW:    return base + i + (is_b * 200);
         default:        return base + i / 3;  // Same list on both sides
      endcase
   endfunction

   function automatic merge_pkg::tuple_t to_tuple(input int unsigned keys [$], int first);
      merge_pkg::tuple_t t;
      for (int k = 0; k < TN; k++) begin
         t[k] = keys[first + k];
      end
      return t;
   endfunction

   function automatic logic keys_ascending(merge_pkg::tuple_t t);
      for (int k = 1; k < TN; k++) begin
         if (t[k] < t[k-1]) return 1'b0;
      end
      return 1'b1;
   endfunction

   task automatic build_streams(input case_t c);
      int unsigned keys_a [$];
      int unsigned keys_b [$];
      int unsigned merged [$];
      int unsigned base;
      int unsigned prev;
      int          ia;
      int          ib;
      base = ($urandom % 32'h4000_0000) + 1;  // Keeps every key nonzero
      prev = base;
      for (int i = 0; i < c.len_a * TN; i++) begin
         prev = next_key(c.pattern, 0, i, base, prev);
         keys_a.push_back(prev);
      end
      prev = base;
      for (int i = 0; i < c.len_b * TN; i++) begin
         prev = next_key(c.pattern, 1, i, base, prev);
         keys_b.push_back(prev);
      end
      // Sorted union of both lists
      ia = 0;
      ib = 0;
      while (ia < keys_a.size() || ib < keys_b.size()) begin
         if (ib >= keys_b.size() || (ia < keys_a.size() && keys_a[ia] <= keys_b[ib])) begin
            merged.push_back(keys_a[ia]);
            ia++;
         end else begin
            merged.push_back(keys_b[ib]);
            ib++;
         end
      end
      for (int t = 0; t < c.len_a; t++) q_a.push_back(to_tuple(keys_a, t * TN));
      for (int t = 0; t < c.len_b; t++) q_b.push_back(to_tuple(keys_b, t * TN));
      for (int t = 0; t < c.len_a + c.len_b; t++) exp_q.push_back(to_tuple(merged, t * TN));
      q_a.push_back('0);  // Terminators
      q_b.push_back('0);
      exp_q.push_back('0);
   endtask

   task automatic run_case(input case_t c);
      int   cyc;
      int   idle;
      logic stalled;
      cyc  = 0;
      idle = 0;
      while (exp_q.size() > 0 || idle < IDLE_CYCLES) begin
         @(negedge i_clk);
         stalled      = (cyc >= STALL_START) && (cyc < STALL_START + c.stall_len);
         i_in_a_empty = (q_a.size() == 0) || ($urandom % 4 == 0);
         i_in_b_empty = (q_b.size() == 0) || ($urandom % 4 == 0);
         i_in_a_data  = (q_a.size() > 0) ? q_a[0] : '0;
         i_in_b_data  = (q_b.size() > 0) ? q_b[0] : '0;
         i_out_ready  = !stalled && (($urandom % 100) < c.ready_pct);
         #3;  // Settled, well before the rising edge
         check_value("o_in_a_read", '0, 512'(o_in_a_read & i_in_a_empty));
         check_value("o_in_b_read", '0, 512'(o_in_b_read & i_in_b_empty));
         check_value("o_out_write", '0, 512'(o_out_write & !ready_prev));
         if (o_in_a_read && !i_in_a_empty) void'(q_a.pop_front());
         if (o_in_b_read && !i_in_b_empty) void'(q_b.pop_front());
         if (o_out_write && exp_q.size() == 0) begin
            errors++;
            $display("error at %0t: output tuple written after the terminator", $time);
         end else if (o_out_write) begin
            check_value("o_out_data", exp_q.pop_front(), o_out_data);
            check_value("o_out_data order", 512'(1), 512'(keys_ascending(o_out_data)));
         end
         // Input FIFOs still take every upstream tuple while the output is held off
         if (c.stall_len >= 60 && cyc == STALL_START + c.stall_len - 1) begin
            check_value("upstream tuples left in stall", '0, 512'(q_a.size() + q_b.size()));
         end
         if (exp_q.size() == 0) idle++;
         ready_prev = i_out_ready;
         cyc++;
      end
   endtask

   // ==============================
   // Main sequence
   // ==============================

   initial begin
      void'($urandom(SEED));
      i_arst_n     = 1'b0;
      i_in_a_data  = '0;
      i_in_a_empty = 1'b1;
      i_in_b_data  = '0;
      i_in_b_empty = 1'b1;
      i_out_ready  = 1'b0;
      ready_prev   = 1'b0;
      repeat (RESET_CYCLES) @(negedge i_clk);
      i_arst_n    = 1'b1;
      i_out_ready = 1'b1;
      repeat (4) begin  // Nothing offered yet
         @(negedge i_clk);
         #3;
         check_value("o_in_a_read", '0, 512'(o_in_a_read));
         check_value("o_in_b_read", '0, 512'(o_in_b_read));
         check_value("o_out_write", '0, 512'(o_out_write));
      end
      ready_prev = 1'b1;
      for (int n = 0; n < NUM_CASES; n++) begin
         build_streams(CASES[n]);
         run_case(CASES[n]);
      end
      print_summary();
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("timeout: the DUT did not complete all cases in time");
      print_summary();
      $display("TEST FAILED");
      $finish;
   end

endmodule

//--- flist.f
+incdir+tb
src/merge_pkg.sv
src/tuple_fifo.sv
src/merge_control.sv
src/bitonic_merge_stage.sv
src/tuple_merger.sv
tb/tb_tuple_merger.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_tuple_merger -f flist.f -o sim_tuple_merger

./obj_dir/sim_tuple_merger | tee sim.log

if grep -q "TEST FAILED" sim.log; then
   exit 1
fi
grep -q "TEST OK" sim.log
